/* source/ls_pkg.sv */
package ls_pkg;

  // reorder buffer tag, zero means no producer
  typedef logic [3:0] rob_id_t;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  localparam int LINE_BYTES = 16;
  localparam int OFFSET_W = $clog2(LINE_BYTES);

  typedef logic [LINE_BYTES*8-1:0] line_t;

  // loads first, the store class is the last three codes
  typedef enum logic [3:0] {
    LB,
    LH,
    LW,
    LBU,
    LHU,
    SB,
    SH,
    SW
  } ls_op_t;

  typedef enum logic [1:0] {
    IDLE,
    WRITE_BACK,
    REFILL
  } cache_state_t;

  function automatic logic is_store(ls_op_t op);
    return op >= SB;
  endfunction

endpackage

/* source/ls_queue.sv */
`timescale 1ns/1ps

module ls_queue #(
  parameter int LSB_DEPTH = 8
) (
  input  logic              clk,
  input  logic              reset_from_rob_bus,
  input  ls_pkg::rob_id_t   dest_from_issuer,
  input  ls_pkg::ls_op_t    op_from_issuer,
  input  ls_pkg::rob_id_t   qj_from_issuer,
  input  ls_pkg::rob_id_t   qk_from_issuer,
  input  ls_pkg::word_t     vj_from_issuer,
  input  ls_pkg::word_t     vk_from_issuer,
  input  ls_pkg::word_t     a_from_issuer,
  input  ls_pkg::rob_id_t   dest_from_rss_bus,
  input  ls_pkg::word_t     value_from_rss_bus,
  input  ls_pkg::rob_id_t   dest_from_lsb_bus,
  input  ls_pkg::word_t     value_from_lsb_bus,
  input  ls_pkg::rob_id_t   dest_from_rob_bus,
  input  logic              head_done,
  output logic              head_valid,
  output ls_pkg::ls_op_t    head_op,
  output ls_pkg::addr_t     head_addr,
  output ls_pkg::word_t     head_store_data,
  output ls_pkg::rob_id_t   head_dest,
  output logic              is_ls_buffer_full
);

  localparam int PTR_W = $clog2(LSB_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  ls_pkg::ls_op_t  op [LSB_DEPTH];
  ls_pkg::rob_id_t qj [LSB_DEPTH];
  ls_pkg::rob_id_t qk [LSB_DEPTH];
  ls_pkg::word_t   vj [LSB_DEPTH];
  ls_pkg::word_t   vk [LSB_DEPTH];
  ls_pkg::word_t   a [LSB_DEPTH];
  ls_pkg::rob_id_t dest [LSB_DEPTH];
  logic [LSB_DEPTH-1:0] busy;
  logic [LSB_DEPTH-1:0] committed;

  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [CNT_W-1:0] count;

  logic             issue;
  logic             calc_found;
  logic [PTR_W-1:0] calc_idx;

  assign issue = dest_from_issuer != '0;
  assign is_ls_buffer_full = count >= CNT_W'(LSB_DEPTH - 1);

  assign head_op = op[head];
  assign head_addr = vj[head];
  assign head_store_data = vk[head];
  assign head_dest = dest[head];
  assign head_valid = busy[head] && qj[head] == '0 && qk[head] == '0 && a[head] == '0
                      && (!ls_pkg::is_store(op[head]) || committed[head]);

  // lowest entry with its base ready and an offset still to add
  always_comb begin
    calc_found = 1'b0;
    calc_idx = '0;
    for (int i = LSB_DEPTH - 1; i >= 0; i--) begin
      if (busy[i] && qj[i] == '0 && a[i] != '0) begin
        calc_found = 1'b1;
        calc_idx = PTR_W'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (calc_found) begin
      vj[calc_idx] <= vj[calc_idx] + a[calc_idx];
      a[calc_idx] <= '0;
    end
    // rss bus is written last so it wins a tie
    for (int i = 0; i < LSB_DEPTH; i++) begin
      if (dest_from_lsb_bus != '0 && qj[i] == dest_from_lsb_bus) begin
        qj[i] <= '0;
        vj[i] <= value_from_lsb_bus;
      end
      if (dest_from_lsb_bus != '0 && qk[i] == dest_from_lsb_bus) begin
        qk[i] <= '0;
        vk[i] <= value_from_lsb_bus;
      end
      if (dest_from_rss_bus != '0 && qj[i] == dest_from_rss_bus) begin
        qj[i] <= '0;
        vj[i] <= value_from_rss_bus;
      end
      if (dest_from_rss_bus != '0 && qk[i] == dest_from_rss_bus) begin
        qk[i] <= '0;
        vk[i] <= value_from_rss_bus;
      end
    end
    if (issue) begin
      op[tail] <= op_from_issuer;
      a[tail] <= a_from_issuer;
      dest[tail] <= dest_from_issuer;
      // operand may arrive on a bus in the issue cycle itself
      if (dest_from_rss_bus != '0 && qj_from_issuer == dest_from_rss_bus) begin
        qj[tail] <= '0;
        vj[tail] <= value_from_rss_bus;
      end else if (dest_from_lsb_bus != '0 && qj_from_issuer == dest_from_lsb_bus) begin
        qj[tail] <= '0;
        vj[tail] <= value_from_lsb_bus;
      end else begin
        qj[tail] <= qj_from_issuer;
        vj[tail] <= vj_from_issuer;
      end
      if (dest_from_rss_bus != '0 && qk_from_issuer == dest_from_rss_bus) begin
        qk[tail] <= '0;
        vk[tail] <= value_from_rss_bus;
      end else if (dest_from_lsb_bus != '0 && qk_from_issuer == dest_from_lsb_bus) begin
        qk[tail] <= '0;
        vk[tail] <= value_from_lsb_bus;
      end else begin
        qk[tail] <= qk_from_issuer;
        vk[tail] <= vk_from_issuer;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset_from_rob_bus) begin
      head <= '0;
      tail <= '0;
      count <= '0;
      busy <= '0;
      committed <= '0;
    end else begin
      if (dest_from_rob_bus != '0) begin
        for (int i = 0; i < LSB_DEPTH; i++) begin
          if (busy[i] && dest[i] == dest_from_rob_bus) begin
            committed[i] <= 1'b1;
          end
        end
      end
      if (head_done) begin
        busy[head] <= 1'b0;
        committed[head] <= 1'b0;
        head <= head + 1'b1;
      end
      if (issue) begin
        busy[tail] <= 1'b1;
        committed[tail] <= 1'b0;
        tail <= tail + 1'b1;
      end
      case ({issue, head_done})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* source/ls_data_cache.sv */
`timescale 1ns/1ps

module ls_data_cache #(
  parameter int CACHE_LINES = 8
) (
  input  logic                         clk,
  input  logic                         reset_from_rob_bus,
  input  logic                         head_valid,
  input  ls_pkg::ls_op_t               head_op,
  input  ls_pkg::addr_t                head_addr,
  input  ls_pkg::word_t                head_store_data,
  input  ls_pkg::rob_id_t              head_dest,
  input  logic                         ready_from_mem_ctrler,
  input  ls_pkg::line_t                cache_line_from_mem_ctrler,
  output logic                         head_done,
  output logic                         load_fire,
  output ls_pkg::line_t                hit_line,
  output ls_pkg::ls_op_t               load_op,
  output logic [ls_pkg::OFFSET_W-1:0]  load_offset,
  output ls_pkg::rob_id_t              load_dest,
  output logic                         valid_to_mem_ctrler,
  output logic                         rw_flag_to_mem_ctrler,
  output ls_pkg::addr_t                addr_to_mem_ctrler,
  output ls_pkg::line_t                cache_line_to_mem_ctrler
);

  localparam int INDEX_W = $clog2(CACHE_LINES);
  localparam int TAG_W = 32 - INDEX_W - ls_pkg::OFFSET_W;

  logic [TAG_W-1:0] tags [CACHE_LINES];
  ls_pkg::line_t    lines [CACHE_LINES];
  logic [CACHE_LINES-1:0] line_valid;
  logic [CACHE_LINES-1:0] line_dirty;

  ls_pkg::cache_state_t state;

  logic [TAG_W-1:0]            tag;
  logic [INDEX_W-1:0]          index;
  logic [ls_pkg::OFFSET_W-1:0] offset;
  logic [ls_pkg::OFFSET_W+2:0] bit_off;
  logic                        hit;
  logic                        store_hit;

  assign tag = head_addr[31 -: TAG_W];
  assign index = head_addr[ls_pkg::OFFSET_W +: INDEX_W];
  assign offset = head_addr[ls_pkg::OFFSET_W-1:0];
  assign bit_off = {offset, 3'b000};
  assign hit = line_valid[index] && tags[index] == tag;

  // hits complete in the cycle they are presented
  assign head_done = state == ls_pkg::IDLE && head_valid && hit;
  assign store_hit = head_done && ls_pkg::is_store(head_op);
  assign load_fire = head_done && !ls_pkg::is_store(head_op);
  assign hit_line = lines[index];
  assign load_op = head_op;
  assign load_offset = offset;
  assign load_dest = head_dest;

  always_ff @(posedge clk) begin
    if (reset_from_rob_bus) begin
      state <= ls_pkg::IDLE;
      valid_to_mem_ctrler <= 1'b0;
      line_valid <= '0;
      line_dirty <= '0;
    end else begin
      case (state)
        ls_pkg::IDLE: begin
          if (head_valid && !hit) begin
            state <= (line_valid[index] && line_dirty[index]) ?
                     ls_pkg::WRITE_BACK : ls_pkg::REFILL;
          end else if (store_hit) begin
            line_dirty[index] <= 1'b1;
          end
        end
        ls_pkg::WRITE_BACK: begin
          if (!valid_to_mem_ctrler) begin
            valid_to_mem_ctrler <= 1'b1;
          end else if (ready_from_mem_ctrler) begin
            // valid drops for a cycle before the refill request
            valid_to_mem_ctrler <= 1'b0;
            line_dirty[index] <= 1'b0;
            state <= ls_pkg::REFILL;
          end
        end
        ls_pkg::REFILL: begin
          if (!valid_to_mem_ctrler) begin
            valid_to_mem_ctrler <= 1'b1;
          end else if (ready_from_mem_ctrler) begin
            valid_to_mem_ctrler <= 1'b0;
            line_valid[index] <= 1'b1;
            line_dirty[index] <= 1'b0;
            state <= ls_pkg::IDLE;
          end
        end
        default: state <= ls_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (store_hit) begin
      case (head_op)
        ls_pkg::SB: lines[index][bit_off +: 8] <= head_store_data[7:0];
        ls_pkg::SH: lines[index][bit_off +: 16] <= head_store_data[15:0];
        ls_pkg::SW: lines[index][bit_off +: 32] <= head_store_data;
        default: ;
      endcase
    end
    // request fields load as valid rises
    if (!valid_to_mem_ctrler && state == ls_pkg::WRITE_BACK) begin
      rw_flag_to_mem_ctrler <= 1'b1;
      addr_to_mem_ctrler <= {tags[index], index, {ls_pkg::OFFSET_W{1'b0}}};
      cache_line_to_mem_ctrler <= lines[index];
    end else if (!valid_to_mem_ctrler && state == ls_pkg::REFILL) begin
      rw_flag_to_mem_ctrler <= 1'b0;
      addr_to_mem_ctrler <= {tag, index, {ls_pkg::OFFSET_W{1'b0}}};
    end
    if (state == ls_pkg::REFILL && valid_to_mem_ctrler && ready_from_mem_ctrler) begin
      lines[index] <= cache_line_from_mem_ctrler;
      tags[index] <= tag;
    end
  end

endmodule

/* source/ls_load_result.sv */
`timescale 1ns/1ps

module ls_load_result (
  input  logic                         clk,
  input  logic                         reset_from_rob_bus,
  input  logic                         load_fire,
  input  ls_pkg::line_t                hit_line,
  input  ls_pkg::ls_op_t               load_op,
  input  logic [ls_pkg::OFFSET_W-1:0]  load_offset,
  input  ls_pkg::rob_id_t              load_dest,
  output ls_pkg::rob_id_t              dest_to_lsb_bus,
  output ls_pkg::word_t                value_to_lsb_bus
);

  ls_pkg::line_t shifted;
  ls_pkg::word_t raw;
  ls_pkg::word_t ext_value;

  // accessed bytes land at bit 0
  assign shifted = hit_line >> {load_offset, 3'b000};
  assign raw = shifted[31:0];

  always_comb begin
    case (load_op)
      ls_pkg::LB:  ext_value = {{24{raw[7]}}, raw[7:0]};
      ls_pkg::LH:  ext_value = {{16{raw[15]}}, raw[15:0]};
      ls_pkg::LBU: ext_value = {24'b0, raw[7:0]};
      ls_pkg::LHU: ext_value = {16'b0, raw[15:0]};
      default:     ext_value = raw;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_from_rob_bus) begin
      dest_to_lsb_bus <= '0;
    end else begin
      dest_to_lsb_bus <= load_fire ? load_dest : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (load_fire) begin
      value_to_lsb_bus <= ext_value;
    end
  end

endmodule

/* source/ls_unit.sv */
`timescale 1ns/1ps

module ls_unit #(
  parameter int LSB_DEPTH = 8,
  parameter int CACHE_LINES = 8
) (
  input  logic             clk,
  input  logic             reset_from_rob_bus,
  input  ls_pkg::rob_id_t  dest_from_issuer,
  input  ls_pkg::ls_op_t   op_from_issuer,
  input  ls_pkg::rob_id_t  qj_from_issuer,
  input  ls_pkg::rob_id_t  qk_from_issuer,
  input  ls_pkg::word_t    vj_from_issuer,
  input  ls_pkg::word_t    vk_from_issuer,
  input  ls_pkg::word_t    a_from_issuer,
  input  ls_pkg::rob_id_t  dest_from_rss_bus,
  input  ls_pkg::word_t    value_from_rss_bus,
  input  ls_pkg::rob_id_t  dest_from_rob_bus,
  output logic             is_ls_buffer_full,
  output ls_pkg::rob_id_t  dest_to_lsb_bus,
  output ls_pkg::word_t    value_to_lsb_bus,
  output logic             valid_to_mem_ctrler,
  output logic             rw_flag_to_mem_ctrler,
  output ls_pkg::addr_t    addr_to_mem_ctrler,
  output ls_pkg::line_t    cache_line_to_mem_ctrler,
  input  logic             ready_from_mem_ctrler,
  input  ls_pkg::line_t    cache_line_from_mem_ctrler
);

  logic                        head_valid;
  ls_pkg::ls_op_t              head_op;
  ls_pkg::addr_t               head_addr;
  ls_pkg::word_t               head_store_data;
  ls_pkg::rob_id_t             head_dest;
  logic                        head_done;
  logic                        load_fire;
  ls_pkg::line_t               hit_line;
  ls_pkg::ls_op_t              load_op;
  logic [ls_pkg::OFFSET_W-1:0] load_offset;
  ls_pkg::rob_id_t             load_dest;

  ls_queue #(
    .LSB_DEPTH(LSB_DEPTH)
  ) ls_queue_i (
    .clk(clk),
    .reset_from_rob_bus(reset_from_rob_bus),
    .dest_from_issuer(dest_from_issuer),
    .op_from_issuer(op_from_issuer),
    .qj_from_issuer(qj_from_issuer),
    .qk_from_issuer(qk_from_issuer),
    .vj_from_issuer(vj_from_issuer),
    .vk_from_issuer(vk_from_issuer),
    .a_from_issuer(a_from_issuer),
    .dest_from_rss_bus(dest_from_rss_bus),
    .value_from_rss_bus(value_from_rss_bus),
    // own result bus feeds back for wakeup
    .dest_from_lsb_bus(dest_to_lsb_bus),
    .value_from_lsb_bus(value_to_lsb_bus),
    .dest_from_rob_bus(dest_from_rob_bus),
    .head_done(head_done),
    .head_valid(head_valid),
    .head_op(head_op),
    .head_addr(head_addr),
    .head_store_data(head_store_data),
    .head_dest(head_dest),
    .is_ls_buffer_full(is_ls_buffer_full)
  );

  ls_data_cache #(
    .CACHE_LINES(CACHE_LINES)
  ) ls_data_cache_i (
    .clk(clk),
    .reset_from_rob_bus(reset_from_rob_bus),
    .head_valid(head_valid),
    .head_op(head_op),
    .head_addr(head_addr),
    .head_store_data(head_store_data),
    .head_dest(head_dest),
    .ready_from_mem_ctrler(ready_from_mem_ctrler),
    .cache_line_from_mem_ctrler(cache_line_from_mem_ctrler),
    .head_done(head_done),
    .load_fire(load_fire),
    .hit_line(hit_line),
    .load_op(load_op),
    .load_offset(load_offset),
    .load_dest(load_dest),
    .valid_to_mem_ctrler(valid_to_mem_ctrler),
    .rw_flag_to_mem_ctrler(rw_flag_to_mem_ctrler),
    .addr_to_mem_ctrler(addr_to_mem_ctrler),
    .cache_line_to_mem_ctrler(cache_line_to_mem_ctrler)
  );

  ls_load_result ls_load_result_i (
    .clk(clk),
    .reset_from_rob_bus(reset_from_rob_bus),
    .load_fire(load_fire),
    .hit_line(hit_line),
    .load_op(load_op),
    .load_offset(load_offset),
    .load_dest(load_dest),
    .dest_to_lsb_bus(dest_to_lsb_bus),
    .value_to_lsb_bus(value_to_lsb_bus)
  );

endmodule

/* dv/ls_mem_model.sv */
`timescale 1ns/1ps

module ls_mem_model (
  input  logic            clk,
  input  logic            reset_from_rob_bus,
  input  logic            valid_to_mem_ctrler,
  input  logic            rw_flag_to_mem_ctrler,
  input  ls_pkg::addr_t   addr_to_mem_ctrler,
  input  ls_pkg::line_t   cache_line_to_mem_ctrler,
  output logic            ready_from_mem_ctrler,
  output ls_pkg::line_t   cache_line_from_mem_ctrler
);

  // written-back lines keyed by line address
  ls_pkg::line_t stored [ls_pkg::addr_t];

  int            read_count;
  int            write_count;
  ls_pkg::addr_t last_write_addr;
  ls_pkg::line_t last_write_line;
  int            wait_cycles;
  logic          served;

  function automatic ls_pkg::line_t read_line(ls_pkg::addr_t base);
    ls_pkg::line_t line;
    if (stored.exists(base)) begin
      return stored[base];
    end
    for (int i = 0; i < ls_pkg::LINE_BYTES; i++) begin
      line[i*8 +: 8] = 8'((base + ls_pkg::addr_t'(i)) * 7 + 3);
    end
    return line;
  endfunction

  always @(posedge clk) begin
    if (reset_from_rob_bus) begin
      ready_from_mem_ctrler <= 1'b0;
      cache_line_from_mem_ctrler <= '0;
      wait_cycles <= 0;
      served <= 1'b0;
      read_count <= 0;
      write_count <= 0;
    end else begin
      ready_from_mem_ctrler <= 1'b0;
      if (!valid_to_mem_ctrler) begin
        wait_cycles <= 0;
        served <= 1'b0;
      end else if (!served) begin
        wait_cycles <= wait_cycles + 1;
        // third cycle after valid rose
        if (wait_cycles == 2) begin
          ready_from_mem_ctrler <= 1'b1;
          served <= 1'b1;
          if (rw_flag_to_mem_ctrler) begin
            stored[addr_to_mem_ctrler] = cache_line_to_mem_ctrler;
            write_count <= write_count + 1;
            last_write_addr <= addr_to_mem_ctrler;
            last_write_line <= cache_line_to_mem_ctrler;
          end else begin
            cache_line_from_mem_ctrler <= read_line(addr_to_mem_ctrler);
            read_count <= read_count + 1;
          end
        end
      end
    end
  end

endmodule

/* dv/ls_unit_sva.sv */
`timescale 1ns/1ps

module ls_unit_sva (
  input logic            clk,
  input logic            reset_from_rob_bus,
  input logic            valid_to_mem_ctrler,
  input logic            ready_from_mem_ctrler,
  input logic            rw_flag_to_mem_ctrler,
  input ls_pkg::addr_t   addr_to_mem_ctrler,
  input ls_pkg::line_t   cache_line_to_mem_ctrler,
  input ls_pkg::rob_id_t dest_to_lsb_bus
);

  // request stays up until the controller answers
  valid_held: assert property (@(posedge clk) disable iff (reset_from_rob_bus)
    valid_to_mem_ctrler && !ready_from_mem_ctrler |=> valid_to_mem_ctrler)
    else $error("memory request valid dropped before ready");

  fields_stable: assert property (@(posedge clk) disable iff (reset_from_rob_bus)
    valid_to_mem_ctrler && !ready_from_mem_ctrler
    |=> $stable(rw_flag_to_mem_ctrler) && $stable(addr_to_mem_ctrler))
    else $error("memory request fields changed before ready");

  // only write requests carry a line
  line_stable: assert property (@(posedge clk) disable iff (reset_from_rob_bus)
    valid_to_mem_ctrler && !ready_from_mem_ctrler && rw_flag_to_mem_ctrler
    |=> $stable(cache_line_to_mem_ctrler))
    else $error("write-back line changed before ready");

  result_idle_after_reset: assert property (@(posedge clk)
    reset_from_rob_bus |=> dest_to_lsb_bus == '0)
    else $error("result dest not zero after reset");

endmodule

bind ls_unit ls_unit_sva ls_unit_sva_i (.*);

/* dv/ls_unit_tb.sv */
`timescale 1ns/1ps

module ls_unit_tb;

  localparam int LSB_DEPTH = 8;
  localparam int CACHE_LINES = 8;
  localparam int TIMEOUT = 200;

  logic            clk;
  logic            reset_from_rob_bus;
  ls_pkg::rob_id_t dest_from_issuer;
  ls_pkg::ls_op_t  op_from_issuer;
  ls_pkg::rob_id_t qj_from_issuer;
  ls_pkg::rob_id_t qk_from_issuer;
  ls_pkg::word_t   vj_from_issuer;
  ls_pkg::word_t   vk_from_issuer;
  ls_pkg::word_t   a_from_issuer;
  ls_pkg::rob_id_t dest_from_rss_bus;
  ls_pkg::word_t   value_from_rss_bus;
  ls_pkg::rob_id_t dest_from_rob_bus;
  logic            is_ls_buffer_full;
  ls_pkg::rob_id_t dest_to_lsb_bus;
  ls_pkg::word_t   value_to_lsb_bus;
  logic            valid_to_mem_ctrler;
  logic            rw_flag_to_mem_ctrler;
  ls_pkg::addr_t   addr_to_mem_ctrler;
  ls_pkg::line_t   cache_line_to_mem_ctrler;
  logic            ready_from_mem_ctrler;
  ls_pkg::line_t   cache_line_from_mem_ctrler;

  integer          seed;
  int              errors;
  ls_pkg::rob_id_t got_dest [$];
  ls_pkg::word_t   got_value [$];
  // bytes written by stores
  logic [7:0]      shadow [ls_pkg::addr_t];

  ls_unit #(
    .LSB_DEPTH(LSB_DEPTH),
    .CACHE_LINES(CACHE_LINES)
  ) ls_unit_i (.*);

  ls_mem_model mem_i (.*);

  always #2 clk = ~clk;

  // registered result bus is stable at the falling edge
  always @(negedge clk) begin
    if (!reset_from_rob_bus && dest_to_lsb_bus != '0) begin
      got_dest.push_back(dest_to_lsb_bus);
      got_value.push_back(value_to_lsb_bus);
    end
  end

  function automatic logic [7:0] exp_byte(ls_pkg::addr_t x);
    if (shadow.exists(x)) begin
      return shadow[x];
    end
    return 8'(x * 7 + 3);
  endfunction

  function automatic ls_pkg::word_t expect_load(ls_pkg::ls_op_t op, ls_pkg::addr_t x);
    ls_pkg::word_t w;
    w = {exp_byte(x + 3), exp_byte(x + 2), exp_byte(x + 1), exp_byte(x)};
    case (op)
      ls_pkg::LB:  return {{24{w[7]}}, w[7:0]};
      ls_pkg::LBU: return {24'b0, w[7:0]};
      ls_pkg::LH:  return {{16{w[15]}}, w[15:0]};
      ls_pkg::LHU: return {16'b0, w[15:0]};
      default:     return w;
    endcase
  endfunction

  function automatic ls_pkg::addr_t rand_addr();
    return ls_pkg::addr_t'($random(seed)) & 32'h0003_fffc;
  endfunction

  // first aligned access from start whose top byte is negative
  function automatic ls_pkg::addr_t find_negative(ls_pkg::addr_t start, int size);
    ls_pkg::addr_t x;
    logic [7:0]    top;
    for (int i = 0; i < 64; i++) begin
      x = start + ls_pkg::addr_t'(i * size);
      top = exp_byte(x + ls_pkg::addr_t'(size - 1));
      if (top[7]) begin
        return x;
      end
    end
    return start;
  endfunction

  task automatic store_shadow(input ls_pkg::addr_t x, input ls_pkg::word_t data);
    for (int i = 0; i < 4; i++) begin
      shadow[x + ls_pkg::addr_t'(i)] = data[i*8 +: 8];
    end
  endtask

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic issue(input ls_pkg::ls_op_t op, input ls_pkg::rob_id_t dest,
                       input ls_pkg::rob_id_t qj, input ls_pkg::word_t vj,
                       input ls_pkg::word_t vk, input ls_pkg::word_t imm);
    dest_from_issuer = dest;
    op_from_issuer = op;
    qj_from_issuer = qj;
    qk_from_issuer = '0;
    vj_from_issuer = vj;
    vk_from_issuer = vk;
    a_from_issuer = imm;
    tick();
    dest_from_issuer = '0;
  endtask

  task automatic commit(input ls_pkg::rob_id_t dest);
    dest_from_rob_bus = dest;
    tick();
    dest_from_rob_bus = '0;
  endtask

  task automatic expect_result(input string name, input ls_pkg::rob_id_t dest,
                               input ls_pkg::word_t exp);
    int waited;
    ls_pkg::rob_id_t d;
    ls_pkg::word_t v;
    waited = 0;
    while (got_dest.size() == 0 && waited < TIMEOUT) begin
      tick();
      waited++;
    end
    assert (got_dest.size() != 0) else begin
      $display("test %s: no load result within %0d cycles", name, TIMEOUT);
      errors++;
    end
    if (got_dest.size() != 0) begin
      d = got_dest.pop_front();
      v = got_value.pop_front();
      assert (d == dest) else begin
        $display("ERROR %s dest: expected %0d, got %0d", name, dest, d);
        errors++;
      end
      assert (v == exp) else begin
        $display("ERROR %s value: expected %h, got %h", name, exp, v);
        errors++;
      end
    end
  endtask

  task automatic expect_quiet(input string name, input int cycles);
    repeat (cycles) tick();
    assert (got_dest.size() == 0) else begin
      $display("test %s: unexpected load result for dest %0d", name, got_dest[0]);
      errors++;
      got_dest.delete();
      got_value.delete();
    end
  endtask

  task automatic test_miss_hit();
    ls_pkg::addr_t x;
    ls_pkg::addr_t y;
    int reads;
    x = rand_addr();
    y = {x[31:4], x[3:2] + 2'd1, 2'b00};
    reads = mem_i.read_count;
    // base plus immediate goes through the address add
    issue(ls_pkg::LW, 1, 0, x - 4, 0, 4);
    expect_result("miss", 1, expect_load(ls_pkg::LW, x));
    assert (mem_i.read_count == reads + 1) else begin
      $display("ERROR miss reads: expected %0d, got %0d", reads + 1, mem_i.read_count);
      errors++;
    end
    reads = mem_i.read_count;
    issue(ls_pkg::LW, 2, 0, y, 0, 0);
    expect_result("hit", 2, expect_load(ls_pkg::LW, y));
    assert (mem_i.read_count == reads) else begin
      $display("ERROR hit reads: expected %0d, got %0d", reads, mem_i.read_count);
      errors++;
    end
  endtask

  task automatic test_extension();
    ls_pkg::addr_t x;
    x = find_negative(rand_addr(), 1);
    issue(ls_pkg::LB, 1, 0, x, 0, 0);
    expect_result("lb", 1, expect_load(ls_pkg::LB, x));
    issue(ls_pkg::LBU, 2, 0, x, 0, 0);
    expect_result("lbu", 2, expect_load(ls_pkg::LBU, x));
    x = find_negative(rand_addr(), 2);
    issue(ls_pkg::LH, 3, 0, x, 0, 0);
    expect_result("lh", 3, expect_load(ls_pkg::LH, x));
    issue(ls_pkg::LHU, 4, 0, x, 0, 0);
    expect_result("lhu", 4, expect_load(ls_pkg::LHU, x));
  endtask

  task automatic test_wakeup();
    ls_pkg::addr_t base;
    base = rand_addr();
    issue(ls_pkg::LW, 3, 9, 0, 0, 8);
    // second load captures the base in its own issue cycle
    dest_from_rss_bus = 9;
    value_from_rss_bus = base;
    issue(ls_pkg::LW, 4, 9, 0, 0, 4);
    dest_from_rss_bus = '0;
    expect_result("wakeup", 3, expect_load(ls_pkg::LW, base + 8));
    expect_result("wakeup_issue", 4, expect_load(ls_pkg::LW, base + 4));
  endtask

  task automatic test_commit_gate();
    ls_pkg::addr_t x;
    ls_pkg::word_t data;
    int requests;
    x = rand_addr();
    data = $random(seed);
    requests = mem_i.read_count + mem_i.write_count;
    issue(ls_pkg::SW, 5, 0, x, data, 0);
    issue(ls_pkg::LW, 6, 0, x, 0, 0);
    expect_quiet("commit_hold", 20);
    // an uncommitted store that went ahead would refill its line
    assert (mem_i.read_count + mem_i.write_count == requests) else begin
      $display("ERROR commit_hold requests: expected %0d, got %0d", requests,
               mem_i.read_count + mem_i.write_count);
      errors++;
    end
    commit(5);
    store_shadow(x, data);
    expect_result("commit", 6, expect_load(ls_pkg::LW, x));
  endtask

  task automatic test_dirty_evict();
    ls_pkg::addr_t p;
    ls_pkg::addr_t q;
    ls_pkg::word_t data;
    ls_pkg::line_t victim;
    int writes;
    p = rand_addr();
    q = p + CACHE_LINES * ls_pkg::LINE_BYTES;
    data = $random(seed);
    issue(ls_pkg::LW, 7, 0, p, 0, 0);
    expect_result("evict_fill", 7, expect_load(ls_pkg::LW, p));
    issue(ls_pkg::SW, 8, 0, p, data, 0);
    commit(8);
    store_shadow(p, data);
    writes = mem_i.write_count;
    issue(ls_pkg::LW, 10, 0, q, 0, 0);
    expect_result("evict_conflict", 10, expect_load(ls_pkg::LW, q));
    assert (mem_i.write_count == writes + 1) else begin
      $display("ERROR evict writes: expected %0d, got %0d", writes + 1,
               mem_i.write_count);
      errors++;
    end
    victim = mem_i.last_write_line;
    assert (mem_i.last_write_addr == {p[31:4], 4'b0}) else begin
      $display("ERROR evict addr: expected %h, got %h", {p[31:4], 4'b0},
               mem_i.last_write_addr);
      errors++;
    end
    assert (victim[{p[3:0], 3'b000} +: 32] == data) else begin
      $display("ERROR evict data: expected %h, got %h", data,
               victim[{p[3:0], 3'b000} +: 32]);
      errors++;
    end
    issue(ls_pkg::LW, 11, 0, p, 0, 0);
    expect_result("evict_reload", 11, data);
  endtask

  task automatic test_full_reset();
    // tag 15 is never broadcast before the reset
    for (int i = 1; i < LSB_DEPTH; i++) begin
      assert (!is_ls_buffer_full) else begin
        $display("ERROR full flag with %0d entries: expected 0, got 1", i - 1);
        errors++;
      end
      issue(ls_pkg::LW, ls_pkg::rob_id_t'(i), 15, 0, 0, 0);
    end
    assert (is_ls_buffer_full) else begin
      $display("ERROR full flag with %0d entries: expected 1, got 0", LSB_DEPTH - 1);
      errors++;
    end
    reset_from_rob_bus = 1'b1;
    repeat (2) tick();
    reset_from_rob_bus = 1'b0;
    assert (!is_ls_buffer_full) else begin
      $display("ERROR reset flag: expected 0, got 1");
      errors++;
    end
    dest_from_rss_bus = 15;
    value_from_rss_bus = rand_addr();
    tick();
    dest_from_rss_bus = '0;
    expect_quiet("reset", 20);
  endtask

  initial begin
    seed = 32'hf58f_a57e;
    errors = 0;
    clk = 1'b0;
    reset_from_rob_bus = 1'b1;
    dest_from_issuer = '0;
    op_from_issuer = ls_pkg::LB;
    qj_from_issuer = '0;
    qk_from_issuer = '0;
    vj_from_issuer = '0;
    vk_from_issuer = '0;
    a_from_issuer = '0;
    dest_from_rss_bus = '0;
    value_from_rss_bus = '0;
    dest_from_rob_bus = '0;
    repeat (10) @(posedge clk);
    #1;
    reset_from_rob_bus = 1'b0;
    test_miss_hit();
    test_extension();
    test_wakeup();
    test_commit_gate();
    test_dirty_evict();
    test_full_reset();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* flist.f */
source/ls_pkg.sv
source/ls_queue.sv
source/ls_data_cache.sv
source/ls_load_result.sv
source/ls_unit.sv
dv/ls_mem_model.sv
dv/ls_unit_sva.sv
dv/ls_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= ls_unit_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
